// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --assert -j 0
TOP       ?= tb_pmp
FILELIST  ?= build.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
pmp_pkg.sv
pmp_cfg_legalize.sv
pmp_region_match.sv
pmp_csr_regs.sv
pmp_access_check.sv
pmp_top.sv
tb_pmp.sv

// File: pmp_access_check.sv
// No MML permission semantics; privilege other than M is checked like U
module pmp_access_check (
  input  pmp_pkg::acc_req_t   acc_req_i,
  input  pmp_pkg::pmp_state_t state_i,
  output logic                allowed_o
);
  import pmp_pkg::*;

  logic [NUM_REGIONS-1:0] region_match;
  logic                   hit_any;
  pmp_cfg_t               hit_cfg;
  logic                   perm;
  logic                   is_mmode;

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region
    pmp_addr_t addr_below;

    // TOR of entry 0 starts at address zero
    if (i == 0) begin : g_first
      assign addr_below = '0;
    end else begin : g_rest
      assign addr_below = state_i.addr[i-1];
    end

    pmp_region_match i_match (
      .addr_i          (acc_req_i.addr),
      .mode_i          (state_i.cfg[i].mode),
      .pmpaddr_i       (state_i.addr[i]),
      .pmpaddr_below_i (addr_below),
      .match_o         (region_match[i])
    );
  end

  // Lowest index wins, so scan downwards
  always_comb begin
    hit_any = 1'b0;
    hit_cfg = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        hit_any = 1'b1;
        hit_cfg = state_i.cfg[i];
      end
    end
  end

  always_comb begin
    case (acc_req_i.acc)
      ACC_READ:  perm = hit_cfg.read;
      ACC_WRITE: perm = hit_cfg.write;
      ACC_EXEC:  perm = hit_cfg.exec;
      default:   perm = 1'b0;
    endcase
  end

  assign is_mmode = (acc_req_i.priv == PRIV_M);

  always_comb begin
    if (!hit_any) begin
      allowed_o = is_mmode;
    end else if (is_mmode && !hit_cfg.lock) begin
      // Unlocked entries do not bind M-mode
      allowed_o = 1'b1;
    end else begin
      allowed_o = perm;
    end
  end

  // Default deny for U-mode with no entry matching
  always_comb begin
    if ((acc_req_i.priv == PRIV_U) && (region_match == '0)) begin
      a_umode_default_deny: assert final (!allowed_o);
    end
  end

endmodule

// File: pmp_cfg_legalize.sv
// WARL rules for one pmpcfg byte; NA4 stays selectable since G is fixed at 0
module pmp_cfg_legalize (
  input  pmp_pkg::pmp_cfg_t cfg_old_i,
  input  pmp_pkg::pmp_cfg_t cfg_new_i,
  input  pmp_pkg::mseccfg_t mseccfg_i,
  output pmp_pkg::pmp_cfg_t cfg_o
);
  import pmp_pkg::*;

  logic [2:0] rwx_new;
  logic [3:0] lrwx_new;
  logic       rlb_clear;
  logic       locked_exec;
  pmp_cfg_t   cfg_tmp;

  // X W R as stored in the low bits
  assign rwx_new = {cfg_new_i.exec, cfg_new_i.write, cfg_new_i.read};

  // L R W X order for the locked-executable check
  assign lrwx_new = {cfg_new_i.lock, cfg_new_i.read, cfg_new_i.write, cfg_new_i.exec};

  assign rlb_clear = !mseccfg_i.rlb;

  // Encodings MML reserves for M-mode only execute regions
  assign locked_exec = (lrwx_new == 4'b1001) || (lrwx_new == 4'b1010) ||
                       (lrwx_new == 4'b1011) || (lrwx_new == 4'b1101);

  always_comb begin
    cfg_tmp = cfg_new_i;

    // Write without read is reserved unless MML is set
    if (((rwx_new == 3'b010) || (rwx_new == 3'b110)) && !mseccfg_i.mml) begin
      cfg_tmp.exec  = cfg_old_i.exec;
      cfg_tmp.write = cfg_old_i.write;
      cfg_tmp.read  = cfg_old_i.read;
    end

    // Locked entry ignores the write
    if (cfg_old_i.lock && rlb_clear) begin
      cfg_tmp = cfg_old_i;
    end

    if (mseccfg_i.mml && rlb_clear && locked_exec) begin
      cfg_tmp = cfg_old_i;
    end

    // Reserved bits always read as zero
    cfg_tmp.zero = 2'b00;
  end

  assign cfg_o = cfg_tmp;

endmodule

// File: pmp_csr_regs.sv
// Address 0 with we low counts as idle; non-M privilege is treated as U and reads back zero
module pmp_csr_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  pmp_pkg::csr_req_t   csr_req_i,
  output pmp_pkg::word_t      csr_rdata_o,
  output logic                csr_illegal_o,
  output pmp_pkg::pmp_state_t state_o
);
  import pmp_pkg::*;

  pmp_cfg_t  [NUM_REGIONS-1:0] cfg_q;
  pmp_cfg_t  [NUM_REGIONS-1:0] cfg_legal;
  pmp_addr_t [NUM_REGIONS-1:0] addr_q;
  mseccfg_t                    mseccfg_q;

  logic [NUM_REGIONS-1:0] is_addr;
  logic [NUM_REGIONS-1:0] addr_locked;
  logic [NUM_REGIONS-1:0] cfg_lock_bits;
  logic                   is_cfg;
  logic                   is_mseccfg;
  logic                   implemented;
  logic                   pending;
  logic                   illegal;
  logic                   write_en;
  logic                   any_locked;
  word_t                  rdata;

  // Address decode
  assign is_cfg      = (csr_req_i.addr == CSR_PMPCFG0);
  assign is_mseccfg  = (csr_req_i.addr == CSR_MSECCFG);
  assign implemented = is_cfg || is_mseccfg || (|is_addr);

  assign pending  = csr_req_i.we || (csr_req_i.addr != '0);
  assign illegal  = pending && ((csr_req_i.priv != PRIV_M) || !implemented);
  assign write_en = csr_req_i.we && !illegal;

  assign any_locked = |cfg_lock_bits;

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_entry
    assign is_addr[i]       = (csr_req_i.addr == csr_addr_t'(CSR_PMPADDR0 + i));
    assign cfg_lock_bits[i] = cfg_q[i].lock;

    // A locked TOR entry above also freezes this address
    if (i < NUM_REGIONS - 1) begin : g_tor_below
      assign addr_locked[i] = cfg_q[i].lock ||
                              (cfg_q[i+1].lock && (cfg_q[i+1].mode == PMP_TOR));
    end else begin : g_top
      assign addr_locked[i] = cfg_q[i].lock;
    end

    pmp_cfg_legalize i_legalize (
      .cfg_old_i (cfg_q[i]),
      .cfg_new_i (pmp_cfg_t'(csr_req_i.wdata[8*i +: 8])),
      .mseccfg_i (mseccfg_q),
      .cfg_o     (cfg_legal[i])
    );

    a_locked_cfg_stable: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cfg_q[i].lock && !mseccfg_q.rlb |=> $stable(cfg_q[i])
    );
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      mseccfg_q <= '0;
    end else if (write_en) begin
      if (is_cfg) begin
        cfg_q <= cfg_legal;
      end
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (is_addr[i] && (!addr_locked[i] || mseccfg_q.rlb)) begin
          addr_q[i] <= csr_req_i.wdata;
        end
      end
      if (is_mseccfg) begin
        // MML can only be set
        mseccfg_q.mml <= mseccfg_q.mml | csr_req_i.wdata[MSECCFG_MML_BIT];
        // RLB frozen once something is locked
        if (!any_locked || mseccfg_q.rlb) begin
          mseccfg_q.rlb <= csr_req_i.wdata[MSECCFG_RLB_BIT];
        end
      end
    end
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (is_cfg) begin
      rdata = word_t'(cfg_q);
    end else if (is_mseccfg) begin
      rdata[MSECCFG_MML_BIT] = mseccfg_q.mml;
      rdata[MSECCFG_RLB_BIT] = mseccfg_q.rlb;
    end else begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (is_addr[i]) begin
          rdata = addr_q[i];
        end
      end
    end
  end

  assign csr_rdata_o   = illegal ? '0 : rdata;
  assign csr_illegal_o = illegal;

  assign state_o.cfg     = cfg_q;
  assign state_o.addr    = addr_q;
  assign state_o.mseccfg = mseccfg_q;

  // Sticky until reset
  a_mml_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mseccfg_q.mml |=> mseccfg_q.mml
  );

endmodule

// File: pmp_pkg.sv
// Four PMP entries with G fixed at 0; no MMWP, no mseccfgh, no debug region
package pmp_pkg;

  // Entry count, the pmpcfg0 byte layout relies on exactly four
  localparam int unsigned NUM_REGIONS = 4;

  // Plain vector widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word_t;

  // pmpaddr holds physical address bits 33 to 2
  typedef logic [31:0] pmp_addr_t;

  // Implemented CSRs
  localparam csr_addr_t CSR_PMPCFG0  = 12'h3A0;
  localparam csr_addr_t CSR_PMPADDR0 = 12'h3B0;
  localparam csr_addr_t CSR_MSECCFG  = 12'h747;

  // mseccfg bit positions
  localparam int unsigned MSECCFG_MML_BIT = 0;
  localparam int unsigned MSECCFG_RLB_BIT = 2;

  // Address-matching mode, the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'b00,
    ACC_WRITE = 2'b01,
    ACC_EXEC  = 2'b10
  } acc_type_e;

  // One pmpcfg byte, L 00 A X W R
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef struct packed {
    logic rlb;
    logic mml;
  } mseccfg_t;

  // One CSR request, read when we is low
  typedef struct packed {
    logic      we;
    priv_e     priv;
    csr_addr_t addr;
    word_t     wdata;
  } csr_req_t;

  // Whole register state as seen by the checker
  typedef struct packed {
    pmp_cfg_t  [NUM_REGIONS-1:0] cfg;
    pmp_addr_t [NUM_REGIONS-1:0] addr;
    mseccfg_t                    mseccfg;
  } pmp_state_t;

  typedef struct packed {
    word_t     addr;
    acc_type_e acc;
    priv_e     priv;
  } acc_req_t;

endpackage

// File: pmp_region_match.sv
// Word-granular match of one entry; only the low 32 bits of the 34-bit space are reachable
module pmp_region_match (
  input  pmp_pkg::word_t     addr_i,
  input  pmp_pkg::pmp_mode_e mode_i,
  input  pmp_pkg::pmp_addr_t pmpaddr_i,
  input  pmp_pkg::pmp_addr_t pmpaddr_below_i,
  output logic               match_o
);
  import pmp_pkg::*;

  pmp_addr_t word_addr;
  pmp_addr_t napot_mask;
  logic      match_tor;
  logic      match_na4;
  logic      match_napot;

  // Access address in pmpaddr units
  assign word_addr = {2'b00, addr_i[31:2]};

  // Inclusive lower bound, exclusive upper bound
  assign match_tor = (word_addr >= pmpaddr_below_i) && (word_addr < pmpaddr_i);

  assign match_na4 = (word_addr == pmpaddr_i);

  // Trailing ones plus the first zero are don't-care bits
  // all ones in pmpaddr gives an empty mask and matches everything
  assign napot_mask  = ~(pmpaddr_i ^ (pmpaddr_i + 32'd1));
  assign match_napot = ((word_addr & napot_mask) == (pmpaddr_i & napot_mask));

  always_comb begin
    case (mode_i)
      PMP_TOR:   match_o = match_tor;
      PMP_NA4:   match_o = match_na4;
      PMP_NAPOT: match_o = match_napot;
      default:   match_o = 1'b0;
    endcase
  end

endmodule

// File: pmp_top.sv
// Single CSR write strobe and a combinational access check, no handshake on either port
module pmp_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  pmp_pkg::csr_req_t csr_req_i,
  output pmp_pkg::word_t    csr_rdata_o,
  output logic              csr_illegal_o,
  input  pmp_pkg::acc_req_t acc_req_i,
  output logic              acc_allowed_o
);
  import pmp_pkg::*;

  pmp_state_t pmp_state;

  // Register file with WARL rules
  pmp_csr_regs i_csr_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_req_i     (csr_req_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .state_o       (pmp_state)
  );

  // Checker sees the stored state from the cycle after a write
  pmp_access_check i_access_check (
    .acc_req_i (acc_req_i),
    .state_i   (pmp_state),
    .allowed_o (acc_allowed_o)
  );

endmodule

// File: tb_pmp.sv
// Outputs are compared at each falling edge against a shadow model; no MML access semantics
module tb_pmp;
  timeunit 1ns;
  timeprecision 1ps;
  import pmp_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic     clk_i;
  logic     rst_ni;
  csr_req_t csr_req;
  acc_req_t acc_req;
  word_t    csr_rdata;
  logic     csr_illegal;
  logic     acc_allowed;

  pmp_state_t shadow;
  integer     seed;
  int         cycle_count;
  word_t      rnd;

  pmp_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_req_i     (csr_req),
    .csr_rdata_o   (csr_rdata),
    .csr_illegal_o (csr_illegal),
    .acc_req_i     (acc_req),
    .acc_allowed_o (acc_allowed)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic is_illegal_csr(input csr_req_t req);
    logic known;
    // Address zero with no strobe is the idle request
    if (!req.we && (req.addr == '0)) return 1'b0;
    known = (req.addr == CSR_PMPCFG0) || (req.addr == CSR_MSECCFG) ||
            ((req.addr >= CSR_PMPADDR0) && (req.addr <= CSR_PMPADDR0 + 12'd3));
    return (req.priv != PRIV_M) || !known;
  endfunction

  function automatic pmp_cfg_t legalize_cfg(input pmp_cfg_t old, input pmp_cfg_t att,
                                            input mseccfg_t ms);
    pmp_cfg_t   res;
    logic [3:0] lrwx;
    lrwx = {att.lock, att.read, att.write, att.exec};
    if (old.lock && !ms.rlb) return old;
    if (ms.mml && !ms.rlb && (lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101})) return old;
    res = att;
    // W without R is reserved while MML is clear
    if (att.write && !att.read && !ms.mml) begin
      res.read  = old.read;
      res.write = old.write;
      res.exec  = old.exec;
    end
    res.zero = 2'b00;
    return res;
  endfunction

  function automatic pmp_state_t apply_csr_write(input pmp_state_t st, input csr_req_t req);
    pmp_state_t nxt;
    logic       frozen;
    logic       any_lock;
    nxt = st;
    if (!req.we || is_illegal_csr(req)) return nxt;
    if (req.addr == CSR_PMPCFG0) begin
      for (int i = 0; i < 4; i++) begin
        nxt.cfg[i] = legalize_cfg(st.cfg[i], pmp_cfg_t'(req.wdata[8*i +: 8]), st.mseccfg);
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (req.addr == csr_addr_t'(CSR_PMPADDR0 + i)) begin
        frozen = st.cfg[i].lock;
        if (i < 3) frozen = frozen || (st.cfg[i+1].lock && (st.cfg[i+1].mode == PMP_TOR));
        if (!frozen || st.mseccfg.rlb) nxt.addr[i] = req.wdata;
      end
    end
    if (req.addr == CSR_MSECCFG) begin
      any_lock = 1'b0;
      for (int i = 0; i < 4; i++) any_lock = any_lock | st.cfg[i].lock;
      nxt.mseccfg.mml = st.mseccfg.mml | req.wdata[MSECCFG_MML_BIT];
      if (!any_lock || st.mseccfg.rlb) nxt.mseccfg.rlb = req.wdata[MSECCFG_RLB_BIT];
    end
    return nxt;
  endfunction

  function automatic word_t expected_rdata(input pmp_state_t st, input csr_req_t req);
    word_t r;
    r = '0;
    if (is_illegal_csr(req)) return r;
    if (req.addr == CSR_PMPCFG0) begin
      for (int i = 0; i < 4; i++) r[8*i +: 8] = st.cfg[i];
    end else if (req.addr == CSR_MSECCFG) begin
      r[MSECCFG_MML_BIT] = st.mseccfg.mml;
      r[MSECCFG_RLB_BIT] = st.mseccfg.rlb;
    end
    for (int i = 0; i < 4; i++) begin
      if (req.addr == csr_addr_t'(CSR_PMPADDR0 + i)) r = st.addr[i];
    end
    return r;
  endfunction

  function automatic logic region_hit(input word_t w, input pmp_mode_e mode,
                                      input pmp_addr_t a, input pmp_addr_t below);
    int k;
    case (mode)
      PMP_TOR: return (w >= below) && (w < a);
      PMP_NA4: return w == a;
      PMP_NAPOT: begin
        k = 0;
        while ((k < 32) && a[k]) k++;
        // Region of 2^(k+1) words
        if (k >= 31) return 1'b1;
        return (w >> (k + 1)) == (a >> (k + 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic access_allowed(input pmp_state_t st, input acc_req_t ar);
    word_t     w;
    pmp_addr_t below;
    logic      hit;
    pmp_cfg_t  cfg;
    w = {2'b00, ar.addr[31:2]};
    hit = 1'b0;
    cfg = '0;
    for (int i = 0; i < 4; i++) begin
      below = '0;
      if (i > 0) below = st.addr[i-1];
      if (!hit && region_hit(w, st.cfg[i].mode, st.addr[i], below)) begin
        hit = 1'b1;
        cfg = st.cfg[i];
      end
    end
    if (!hit) return ar.priv == PRIV_M;
    if ((ar.priv == PRIV_M) && !cfg.lock) return 1'b1;
    case (ar.acc)
      ACC_READ:  return cfg.read;
      ACC_WRITE: return cfg.write;
      ACC_EXEC:  return cfg.exec;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "illegal flag mismatch");
    end
  endtask

  task automatic check_allowed(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "access decision mismatch");
    end
  endtask

  // Shadow state follows every accepted write
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow <= '0;
    end else begin
      shadow <= apply_csr_write(shadow, csr_req);
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_word("csr_rdata_o", expected_rdata(shadow, csr_req), csr_rdata);
      check_flag("csr_illegal_o", is_illegal_csr(csr_req), csr_illegal);
      check_allowed("acc_allowed_o", access_allowed(shadow, acc_req), acc_allowed);
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic idle_inputs();
    csr_req = '{we: 1'b0, priv: PRIV_M, addr: '0, wdata: '0};
    acc_req = '{addr: '0, acc: ACC_READ, priv: PRIV_M};
  endtask

  // Tasks start and end 10 ns after a rising edge
  task automatic apply_reset();
    idle_inputs();
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
  endtask

  task automatic drive_csr_write(input csr_addr_t addr, input word_t data, input priv_e priv);
    csr_req = '{we: 1'b1, priv: priv, addr: addr, wdata: data};
    @(posedge clk_i);
    #10;
    csr_req = '{we: 1'b0, priv: PRIV_M, addr: '0, wdata: '0};
  endtask

  task automatic read_and_expect(input csr_addr_t addr, input word_t exp, input string name);
    csr_req = '{we: 1'b0, priv: PRIV_M, addr: addr, wdata: '0};
    @(negedge clk_i);
    check_word(name, exp, csr_rdata);
    @(posedge clk_i);
    #10;
  endtask

  task automatic drive_access(input word_t addr, input acc_type_e acc, input priv_e priv);
    acc_req = '{addr: addr, acc: acc, priv: priv};
    @(posedge clk_i);
    #10;
  endtask

  initial begin
    seed = 82;
    cycle_count = 0;
    rst_ni = 1'b0;
    idle_inputs();
    apply_reset();

    // Read-back and WARL legalization
    drive_csr_write(CSR_PMPCFG0, 32'h0000_0001, PRIV_M);
    drive_csr_write(CSR_PMPCFG0, 32'h0000_0002, PRIV_M);
    read_and_expect(CSR_PMPCFG0, 32'h0000_0001, "pmpcfg0 after RW=01");
    for (int n = 0; n < 60; n++) begin
      rnd = $random(seed);
      drive_csr_write(CSR_PMPCFG0, rnd & 32'h7F7F_7F7F, PRIV_M);
      csr_req = '{we: 1'b0, priv: PRIV_M, addr: CSR_PMPCFG0, wdata: '0};
      @(negedge clk_i);
      check_word("pmpcfg0 reserved bits", '0, csr_rdata & 32'h6060_6060);
      @(posedge clk_i);
      #10;
      rnd = $random(seed);
      drive_csr_write(csr_addr_t'(CSR_PMPADDR0 + (n % 4)), rnd, PRIV_M);
      read_and_expect(csr_addr_t'(CSR_PMPADDR0 + (n % 4)), rnd, "pmpaddr read-back");
    end

    // Locked TOR entry freezes itself and the address below
    apply_reset();
    drive_csr_write(CSR_PMPADDR0, 32'h100, PRIV_M);
    drive_csr_write(CSR_PMPADDR0 + 12'd1, 32'h200, PRIV_M);
    drive_csr_write(CSR_PMPCFG0, 32'h0000_8F00, PRIV_M);
    drive_csr_write(CSR_PMPCFG0, 32'h0000_0000, PRIV_M);
    drive_csr_write(CSR_PMPADDR0 + 12'd1, 32'h999, PRIV_M);
    drive_csr_write(CSR_PMPADDR0, 32'h555, PRIV_M);
    read_and_expect(CSR_PMPCFG0, 32'h0000_8F00, "locked pmpcfg0");
    read_and_expect(CSR_PMPADDR0 + 12'd1, 32'h200, "locked pmpaddr1");
    read_and_expect(CSR_PMPADDR0, 32'h100, "pmpaddr0 below TOR");
    apply_reset();
    drive_csr_write(CSR_MSECCFG, 32'h4, PRIV_M);
    read_and_expect(CSR_MSECCFG, 32'h4, "mseccfg with RLB");
    drive_csr_write(CSR_PMPCFG0, 32'h0000_8F00, PRIV_M);
    drive_csr_write(CSR_PMPADDR0 + 12'd1, 32'h999, PRIV_M);
    drive_csr_write(CSR_PMPADDR0, 32'h555, PRIV_M);
    drive_csr_write(CSR_PMPCFG0, 32'h0000_0F00, PRIV_M);
    read_and_expect(CSR_PMPADDR0 + 12'd1, 32'h999, "pmpaddr1 under RLB");
    read_and_expect(CSR_PMPADDR0, 32'h555, "pmpaddr0 under RLB");
    read_and_expect(CSR_PMPCFG0, 32'h0000_0F00, "pmpcfg0 under RLB");

    // RLB after lock, sticky MML, locked-executable rejection
    apply_reset();
    drive_csr_write(CSR_PMPCFG0, 32'h0000_0091, PRIV_M);
    drive_csr_write(CSR_MSECCFG, 32'h4, PRIV_M);
    read_and_expect(CSR_MSECCFG, 32'h0, "RLB after lock");
    drive_csr_write(CSR_MSECCFG, 32'h1, PRIV_M);
    drive_csr_write(CSR_MSECCFG, 32'h0, PRIV_M);
    read_and_expect(CSR_MSECCFG, 32'h1, "sticky MML");
    drive_csr_write(CSR_PMPCFG0, 32'h0081_8491, PRIV_M);
    read_and_expect(CSR_PMPCFG0, 32'h0081_0091, "locked-executable write");

    // Illegal CSR accesses
    apply_reset();
    csr_req = '{we: 1'b1, priv: PRIV_U, addr: CSR_PMPADDR0, wdata: 32'h1234};
    @(negedge clk_i);
    check_flag("csr_illegal_o on U-mode write", 1'b1, csr_illegal);
    @(posedge clk_i);
    #10;
    read_and_expect(CSR_PMPADDR0, 32'h0, "pmpaddr0 after U-mode write");
    csr_req = '{we: 1'b0, priv: PRIV_M, addr: 12'h3B8, wdata: '0};
    @(negedge clk_i);
    check_word("unimplemented read data", 32'h0, csr_rdata);
    check_flag("csr_illegal_o on unimplemented read", 1'b1, csr_illegal);
    @(posedge clk_i);
    #10;

    // Random regions and random accesses
    for (int r = 0; r < 20; r++) begin
      apply_reset();
      for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        drive_csr_write(csr_addr_t'(CSR_PMPADDR0 + i), rnd & 32'h3F, PRIV_M);
      end
      rnd = $random(seed);
      drive_csr_write(CSR_PMPCFG0, rnd & 32'h9F9F_9F9F, PRIV_M);
      for (int n = 0; n < 40; n++) begin
        rnd = $random(seed);
        drive_access(rnd & 32'hFF, acc_type_e'(rnd[9:8] % 2'd3), rnd[12] ? PRIV_M : PRIV_U);
      end
    end

    idle_inputs();
    @(posedge clk_i);
    #10;
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
